/* compile.f */
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/dispatch_window.sv
hdl/decode_dispatch.sv
test/clock_gen.sv
test/tb_decode_dispatch.sv

/* hdl/decode_dispatch.sv */
// decode_dispatch top module, two instruction decoders feeding the dispatch window
`timescale 1ns/100ps

module decode_dispatch import id_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  fetch_t   fetch0,         // older fetched instruction
  input  fetch_t   fetch1,         // valid only with fetch0 valid
  input  count_t   rob_cap,        // free rob entries
  input  count_t   rs_cap,         // free reservation stations
  output decoded_t slot0,          // dispatched in order, slot0 first
  output decoded_t slot1,
  output count_t   dispatch_num,
  output count_t   fetch_need      // how many fetch may offer next
);

  decoded_t decoded0;              // decode of fetch0
  decoded_t decoded1;              // decode of fetch1

  inst_decoder decoder0 (
    .fetch   (fetch0),
    .decoded (decoded0)
  );

  inst_decoder decoder1 (
    .fetch   (fetch1),
    .decoded (decoded1)
  );

  // raw fetch valids, so illegal instructions still get a slot
  dispatch_window window (
    .clock        (clock),
    .reset        (reset),
    .in0          (decoded0),
    .in1          (decoded1),
    .in_valid0    (fetch0.valid),
    .in_valid1    (fetch1.valid),
    .rob_cap      (rob_cap),
    .rs_cap       (rs_cap),
    .slot0        (slot0),
    .slot1        (slot1),
    .dispatch_num (dispatch_num),
    .fetch_need   (fetch_need)
  );

endmodule

/* hdl/dispatch_window.sv */
// dispatch_window module, two-entry in-order window with dispatch and fetch need counts
`timescale 1ns/100ps

module dispatch_window import id_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  decoded_t in0,            // older of the two offered
  input  decoded_t in1,
  input  logic     in_valid0,      // fetch valid, illegal ones still take a slot
  input  logic     in_valid1,      // only set together with in_valid0
  input  count_t   rob_cap,
  input  count_t   rs_cap,
  output decoded_t slot0,          // oldest held entry
  output decoded_t slot1,
  output count_t   dispatch_num,   // slots below this leave this cycle
  output count_t   fetch_need      // free space after this cycle's dispatch
);

  decoded_t entry0;                // head
  decoded_t entry1;
  decoded_t next0;
  decoded_t next1;
  count_t   held;                  // occupied entries
  count_t   cap;                   // tighter of rob and rs
  count_t   survivors;             // entries left after dispatch
  count_t   offered;
  count_t   accepted;
  count_t   held_next;

  assign cap          = (rob_cap < rs_cap) ? rob_cap : rs_cap;
  assign dispatch_num = (held < cap) ? held : cap;
  assign survivors    = held - dispatch_num;
  assign fetch_need   = 2'd2 - survivors;
  assign offered      = in_valid0 ? (in_valid1 ? 2'd2 : 2'd1) : 2'd0;
  assign accepted     = (offered < fetch_need) ? offered : fetch_need;   // first ones win
  assign held_next    = survivors + accepted;

  assign slot0 = entry0;
  assign slot1 = entry1;

  // survivor shifts to the head, accepted inputs fill behind it
  always_comb
  begin
    case (survivors)
      2'd0:
      begin
        next0 = in0;
        next1 = in1;
      end
      2'd1:
      begin
        next0 = (dispatch_num == 2'd0) ? entry0 : entry1;   // lone entry or the younger one
        next1 = in0;
      end
      default:
      begin
        next0 = entry0;    // full and stalled
        next1 = entry1;
      end
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      held <= 2'd0;
    else
      held <= held_next;
  end

  // payload only loads into positions that end up occupied
  always_ff @(posedge clock)
  begin
    if (held_next != 2'd0)
      entry0 <= next0;
    if (held_next == 2'd2)
      entry1 <= next1;
  end

  // the offered count assumes fetch1 never arrives alone
  valid_in_order: assert property (
    @(posedge clock) disable iff (reset) in_valid1 |-> in_valid0
  ) else $error("second input valid without the first");

  held_within_depth: assert property (
    @(posedge clock) disable iff (reset) held <= 2'd2
  ) else $error("window occupancy above two");

  // a stalled head must not change under back-pressure
  head_holds_on_stall: assert property (
    @(posedge clock) disable iff (reset)
    (held != 2'd0 && dispatch_num == 2'd0) |=> $stable(entry0)
  ) else $error("head entry changed without dispatch");

endmodule

/* hdl/id_pkg.sv */
// id_pkg package with instruction-set widths, opcode and function enums, fetch and decoded structs
package id_pkg;

  localparam int INST_W = 32;      // alpha instruction word
  localparam int ADDR_W = 64;      // next-pc width
  localparam int REG_W  = 5;       // 32 integer registers
  localparam int FUNC_W = 7;       // operate function field, bits 11..5
  localparam int PAL_W  = 26;      // pal function field, bits 25..0

  typedef logic [INST_W-1:0] inst_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [REG_W-1:0]  reg_idx_t;
  typedef logic [1:0]        count_t;   // 0..2, capacities and counts

  localparam reg_idx_t ZERO_REG = 5'd31;              // r31, no writeback
  localparam logic [PAL_W-1:0] PAL_HALT = 26'h0;      // call_pal halt

  // primary opcodes, bits 31..26
  typedef enum logic [5:0] {
    OP_PAL   = 6'h00,
    OP_LDA   = 6'h08,
    OP_INTA  = 6'h10,   // integer arithmetic
    OP_INTL  = 6'h11,   // integer logical
    OP_INTS  = 6'h12,   // integer shift
    OP_INTM  = 6'h13,   // integer multiply
    OP_JSR   = 6'h1a,   // jmp, jsr, ret, jsr_co
    OP_LDQ   = 6'h29,
    OP_LDQ_L = 6'h2b,
    OP_STQ   = 6'h2d,
    OP_STQ_C = 6'h2f,
    OP_BR    = 6'h30,
    OP_BSR   = 6'h34
  } opcode_e;

  // Function codes repeat between operate groups (0x20 is ADDQ, BIS and MULQ),
  // so each group gets its own enum over the same 7-bit field.
  typedef enum logic [FUNC_W-1:0] {
    ARITH_CMPULT = 7'h1d,
    ARITH_ADDQ   = 7'h20,
    ARITH_SUBQ   = 7'h29,
    ARITH_CMPEQ  = 7'h2d,
    ARITH_CMPULE = 7'h3d,
    ARITH_CMPLT  = 7'h4d,
    ARITH_CMPLE  = 7'h6d
  } arith_func_e;

  typedef enum logic [FUNC_W-1:0] {
    LOGIC_AND   = 7'h00,
    LOGIC_BIC   = 7'h08,
    LOGIC_BIS   = 7'h20,
    LOGIC_ORNOT = 7'h28,
    LOGIC_XOR   = 7'h40,
    LOGIC_EQV   = 7'h48
  } logic_func_e;

  typedef enum logic [FUNC_W-1:0] {
    SHIFT_SRL = 7'h34,
    SHIFT_SLL = 7'h39,
    SHIFT_SRA = 7'h3c
  } shift_func_e;

  typedef enum logic [FUNC_W-1:0] {
    MULT_MULQ = 7'h20
  } mult_func_e;

  // alu operations, ADDQ is 0 so a cleared field is a harmless add
  typedef enum logic [4:0] {
    ALU_ADDQ,
    ALU_SUBQ,
    ALU_CMPEQ,
    ALU_CMPLT,
    ALU_CMPLE,
    ALU_CMPULT,
    ALU_CMPULE,
    ALU_AND,
    ALU_BIC,
    ALU_BIS,
    ALU_ORNOT,
    ALU_XOR,
    ALU_EQV,
    ALU_SRL,
    ALU_SLL,
    ALU_SRA,
    ALU_MULQ
  } alu_func_e;

  typedef enum logic [1:0] {
    OPA_REGA,       // register a value
    OPA_MEM_DISP,   // sign-extended memory displacement
    OPA_NPC,        // next pc, branch target base
    OPA_NOT3        // ~64'h3, word-aligns jump targets
  } opa_sel_e;

  typedef enum logic [1:0] {
    OPB_REGB,       // register b value
    OPB_ALU_IMM,    // 8-bit literal, bits 20..13
    OPB_BR_DISP     // branch displacement << 2
  } opb_sel_e;

  // one instruction as offered by fetch, 97 bits
  typedef struct packed {
    inst_t inst;
    addr_t npc;
    logic  valid;
  } fetch_t;

  // decoded controls for one instruction
  typedef struct packed {
    addr_t     npc;
    reg_idx_t  ra_idx;
    reg_idx_t  rb_idx;
    reg_idx_t  rc_idx;
    opa_sel_e  opa_select;
    opb_sel_e  opb_select;
    reg_idx_t  dest_idx;        // ZERO_REG when nothing is written
    alu_func_e alu_func;
    logic      rd_mem;
    logic      wr_mem;
    logic      ldl_mem;         // load-locked
    logic      stc_mem;         // store-conditional
    logic      cond_branch;
    logic      uncond_branch;   // branches and jumps
    logic      halt;
    logic      illegal;
    logic      valid;           // counts as a retired instruction
  } decoded_t;

endpackage

/* hdl/inst_decoder.sv */
// inst_decoder module, combinational decode of one fetched instruction into datapath controls
`timescale 1ns/100ps

module inst_decoder import id_pkg::*; (
  input  fetch_t   fetch,     // word, next-pc, valid
  output decoded_t decoded    // controls, no-op when fetch is invalid
);

  // where the writeback index comes from
  typedef enum logic [1:0] {
    DEST_NONE,
    DEST_REGA,
    DEST_REGC
  } dest_sel_e;

  opcode_e           opcode;
  logic [FUNC_W-1:0] func;
  reg_idx_t          ra_idx;
  reg_idx_t          rb_idx;
  reg_idx_t          rc_idx;
  dest_sel_e         dest_sel;
  logic              func_ok;    // operate function code is known

  assign opcode = opcode_e'(fetch.inst[31:26]);   // values outside the enum fall to default
  assign func   = fetch.inst[11:5];
  assign ra_idx = fetch.inst[25:21];
  assign rb_idx = fetch.inst[20:16];
  assign rc_idx = fetch.inst[4:0];

  always_comb
  begin
    // no-op defaults, every field explicit
    decoded.npc           = fetch.npc;     // passes through
    decoded.ra_idx        = ra_idx;
    decoded.rb_idx        = rb_idx;
    decoded.rc_idx        = rc_idx;
    decoded.opa_select    = OPA_REGA;
    decoded.opb_select    = OPB_REGB;
    decoded.alu_func      = ALU_ADDQ;
    decoded.rd_mem        = 1'b0;
    decoded.wr_mem        = 1'b0;
    decoded.ldl_mem       = 1'b0;
    decoded.stc_mem       = 1'b0;
    decoded.cond_branch   = 1'b0;
    decoded.uncond_branch = 1'b0;
    decoded.halt          = 1'b0;
    decoded.illegal       = 1'b0;
    dest_sel              = DEST_NONE;
    func_ok               = 1'b1;
    if (fetch.valid)
    begin
      case (opcode)
        OP_PAL:
        begin
          if (fetch.inst[PAL_W-1:0] == PAL_HALT)
            decoded.halt = 1'b1;
          else
            decoded.illegal = 1'b1;       // other pal calls unsupported
        end
        OP_INTA, OP_INTL, OP_INTS, OP_INTM:
        begin
          case (opcode)
            OP_INTA:
              case (arith_func_e'(func))
                ARITH_ADDQ:   decoded.alu_func = ALU_ADDQ;
                ARITH_SUBQ:   decoded.alu_func = ALU_SUBQ;
                ARITH_CMPEQ:  decoded.alu_func = ALU_CMPEQ;
                ARITH_CMPLT:  decoded.alu_func = ALU_CMPLT;
                ARITH_CMPLE:  decoded.alu_func = ALU_CMPLE;
                ARITH_CMPULT: decoded.alu_func = ALU_CMPULT;
                ARITH_CMPULE: decoded.alu_func = ALU_CMPULE;
                default:      func_ok = 1'b0;
              endcase
            OP_INTL:
              case (logic_func_e'(func))
                LOGIC_AND:   decoded.alu_func = ALU_AND;
                LOGIC_BIC:   decoded.alu_func = ALU_BIC;
                LOGIC_BIS:   decoded.alu_func = ALU_BIS;
                LOGIC_ORNOT: decoded.alu_func = ALU_ORNOT;
                LOGIC_XOR:   decoded.alu_func = ALU_XOR;
                LOGIC_EQV:   decoded.alu_func = ALU_EQV;
                default:     func_ok = 1'b0;
              endcase
            OP_INTS:
              case (shift_func_e'(func))
                SHIFT_SRL: decoded.alu_func = ALU_SRL;
                SHIFT_SLL: decoded.alu_func = ALU_SLL;
                SHIFT_SRA: decoded.alu_func = ALU_SRA;
                default:   func_ok = 1'b0;
              endcase
            default:
              case (mult_func_e'(func))
                MULT_MULQ: decoded.alu_func = ALU_MULQ;
                default:   func_ok = 1'b0;
              endcase
          endcase
          // operand b and rc only for a known function, illegal stays a no-op
          if (func_ok)
          begin
            decoded.opb_select = fetch.inst[12] ? OPB_ALU_IMM : OPB_REGB;   // literal form
            dest_sel           = DEST_REGC;
          end
          else
          begin
            decoded.illegal = 1'b1;
          end
        end
        OP_LDA, OP_LDQ, OP_LDQ_L, OP_STQ, OP_STQ_C:
        begin
          decoded.opa_select = OPA_MEM_DISP;   // address = disp + rb
          decoded.opb_select = OPB_REGB;
          decoded.alu_func   = ALU_ADDQ;
          dest_sel           = DEST_REGA;
          case (opcode)
            OP_LDQ:
              decoded.rd_mem = 1'b1;
            OP_LDQ_L:
            begin
              decoded.rd_mem  = 1'b1;
              decoded.ldl_mem = 1'b1;
            end
            OP_STQ:
            begin
              decoded.wr_mem = 1'b1;
              dest_sel       = DEST_NONE;      // plain store writes nothing
            end
            OP_STQ_C:
            begin
              decoded.wr_mem  = 1'b1;
              decoded.stc_mem = 1'b1;          // ra gets the success flag
            end
            default: ;                         // lda, just the add
          endcase
        end
        OP_JSR:
        begin
          decoded.opa_select    = OPA_NOT3;    // target = rb & ~3
          decoded.opb_select    = OPB_REGB;
          decoded.alu_func      = ALU_AND;
          dest_sel              = DEST_REGA;   // return address
          decoded.uncond_branch = 1'b1;
        end
        OP_BR, OP_BSR:
        begin
          decoded.opa_select    = OPA_NPC;
          decoded.opb_select    = OPB_BR_DISP;
          decoded.alu_func      = ALU_ADDQ;
          dest_sel              = DEST_REGA;
          decoded.uncond_branch = 1'b1;
        end
        default:
        begin
          // 0x38..0x3f integer conditional branches, the rest unsupported
          if (fetch.inst[31:29] == 3'b111)
          begin
            decoded.opa_select  = OPA_NPC;
            decoded.opb_select  = OPB_BR_DISP;
            decoded.alu_func    = ALU_ADDQ;
            decoded.cond_branch = 1'b1;
          end
          else
          begin
            decoded.illegal = 1'b1;            // fp, misc, fp branches
          end
        end
      endcase
    end
    case (dest_sel)                            // writeback index mux
      DEST_REGA: decoded.dest_idx = ra_idx;
      DEST_REGC: decoded.dest_idx = rc_idx;
      default:   decoded.dest_idx = ZERO_REG;
    endcase
    decoded.valid = fetch.valid && !decoded.illegal;
    // illegal leaves every control at its no-op value, valid included
    assert (!decoded.illegal ||
            (decoded.opa_select == OPA_REGA && decoded.opb_select == OPB_REGB &&
             decoded.alu_func == ALU_ADDQ && decoded.dest_idx == ZERO_REG &&
             {decoded.rd_mem, decoded.wr_mem, decoded.ldl_mem, decoded.stc_mem,
              decoded.cond_branch, decoded.uncond_branch, decoded.halt,
              decoded.valid} == 8'h0))
      else $error("illegal instruction left controls active");
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, then look for the fail message in the log
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert --top-module tb_decode_dispatch -f compile.f \
  -Mdir obj_dir -o tb_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > "$LOG" 2>&1 \
  || echo "*** FAILED ***" >> "$LOG"
! grep -qF '*** FAILED ***' "$LOG" \
  && echo "simulation passed" \
  || { echo "simulation failed, see $LOG"; exit 1; }

/* test/clock_gen.sv */
// clock_gen module, testbench clock and synchronous reset source
`timescale 1ns/100ps

module clock_gen #(
  parameter int PERIOD_NS    = 10,   // full clock period
  parameter int RESET_CYCLES = 8     // rising edges with reset high
) (
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;                   // released right after the last reset edge
  end

endmodule

/* test/tb_decode_dispatch.sv */
// tb_decode_dispatch testbench, random instruction stream, reference decode, window model, watchdog
`timescale 1ns/100ps

module tb_decode_dispatch import id_pkg::*; ();

  localparam int          STREAM_LEN  = 400;
  localparam int          WATCHDOG_NS = (STREAM_LEN * 8 + 100) * 10;
  localparam logic [31:0] SEED        = 32'h86edc794;

  // legal function codes per operate group, packed 7 bits each
  localparam logic [48:0] ARITH_FUNCS = {7'h1d, 7'h20, 7'h29, 7'h2d, 7'h3d, 7'h4d, 7'h6d};
  localparam logic [41:0] LOGIC_FUNCS = {7'h00, 7'h08, 7'h20, 7'h28, 7'h40, 7'h48};
  localparam logic [20:0] SHIFT_FUNCS = {7'h34, 7'h39, 7'h3c};
  // unsupported primary opcodes, 6 bits each: misc, fp and the odd branch slots
  localparam logic [77:0] BAD_OPCODES = {6'h01, 6'h07, 6'h14, 6'h15, 6'h16, 6'h17,
                                         6'h18, 6'h31, 6'h32, 6'h33, 6'h35, 6'h36,
                                         6'h37};

  logic     clock;
  logic     reset;
  fetch_t   fetch0;
  fetch_t   fetch1;
  count_t   rob_cap;
  count_t   rs_cap;
  decoded_t slot0;
  decoded_t slot1;
  count_t   dispatch_num;
  count_t   fetch_need;

  fetch_t   stream [STREAM_LEN];   // instructions in program order
  decoded_t model_q [$];           // expected window contents, head first
  int       idx_q [$];             // stream index of each model entry
  int       pos              = 0;  // first instruction not yet accepted
  int       accepted_cnt     = 0;  // set by the compare process each cycle
  int       dispatched_total = 0;

  clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(8)) clocks (
    .clock (clock),
    .reset (reset)
  );

  decode_dispatch DUT (
    .clock        (clock),
    .reset        (reset),
    .fetch0       (fetch0),
    .fetch1       (fetch1),
    .rob_cap      (rob_cap),
    .rs_cap       (rs_cap),
    .slot0        (slot0),
    .slot1        (slot1),
    .dispatch_num (dispatch_num),
    .fetch_need   (fetch_need)
  );

  function automatic int min_of(input int a, input int b);
    return (a < b) ? a : b;
  endfunction

  // operate group and function to alu op, 0 when the code is unknown
  function automatic logic operate_alu(input logic [1:0] grp, input logic [6:0] fn,
                                       output alu_func_e alu);
    logic known;
    known = 1'b1;
    alu   = ALU_ADDQ;
    case ({grp, fn})
      {2'd0, 7'h20}: alu = ALU_ADDQ;
      {2'd0, 7'h29}: alu = ALU_SUBQ;
      {2'd0, 7'h2d}: alu = ALU_CMPEQ;
      {2'd0, 7'h4d}: alu = ALU_CMPLT;
      {2'd0, 7'h6d}: alu = ALU_CMPLE;
      {2'd0, 7'h1d}: alu = ALU_CMPULT;
      {2'd0, 7'h3d}: alu = ALU_CMPULE;
      {2'd1, 7'h00}: alu = ALU_AND;
      {2'd1, 7'h08}: alu = ALU_BIC;
      {2'd1, 7'h20}: alu = ALU_BIS;
      {2'd1, 7'h28}: alu = ALU_ORNOT;
      {2'd1, 7'h40}: alu = ALU_XOR;
      {2'd1, 7'h48}: alu = ALU_EQV;
      {2'd2, 7'h34}: alu = ALU_SRL;
      {2'd2, 7'h39}: alu = ALU_SLL;
      {2'd2, 7'h3c}: alu = ALU_SRA;
      {2'd3, 7'h20}: alu = ALU_MULQ;
      default:       known = 1'b0;
    endcase
    return known;
  endfunction

  // expected controls straight from the decode table
  function automatic decoded_t ref_decode(input fetch_t f);
    decoded_t   d;
    logic [5:0] op;
    alu_func_e  alu;
    d          = '0;                          // no-op: zero selects, add, no flags
    d.npc      = f.npc;
    d.ra_idx   = f.inst[25:21];
    d.rb_idx   = f.inst[20:16];
    d.rc_idx   = f.inst[4:0];
    d.dest_idx = ZERO_REG;
    op         = f.inst[31:26];
    if (f.valid)
    begin
      if (op == 6'h00)
      begin
        if (f.inst[25:0] == PAL_HALT)
          d.halt = 1'b1;
        else
          d.illegal = 1'b1;                   // other pal calls
      end
      else if (op[5:2] == 4'b0100)            // 0x10..0x13 operate
      begin
        if (operate_alu(op[1:0], f.inst[11:5], alu))
        begin
          d.alu_func   = alu;
          d.opb_select = f.inst[12] ? OPB_ALU_IMM : OPB_REGB;
          d.dest_idx   = f.inst[4:0];
        end
        else
          d.illegal = 1'b1;
      end
      else if (op == 6'h08 || op == 6'h29 || op == 6'h2b || op == 6'h2d || op == 6'h2f)
      begin
        d.opa_select = OPA_MEM_DISP;
        d.opb_select = OPB_REGB;
        d.alu_func   = ALU_ADDQ;
        d.rd_mem     = (op == 6'h29 || op == 6'h2b);
        d.ldl_mem    = (op == 6'h2b);
        d.wr_mem     = (op == 6'h2d || op == 6'h2f);
        d.stc_mem    = (op == 6'h2f);
        if (op != 6'h2d)
          d.dest_idx = f.inst[25:21];         // stq writes nothing
      end
      else if (op == 6'h1a)
      begin
        d.opa_select    = OPA_NOT3;
        d.alu_func      = ALU_AND;
        d.dest_idx      = f.inst[25:21];
        d.uncond_branch = 1'b1;
      end
      else if (op == 6'h30 || op == 6'h34)
      begin
        d.opa_select    = OPA_NPC;
        d.opb_select    = OPB_BR_DISP;
        d.dest_idx      = f.inst[25:21];
        d.uncond_branch = 1'b1;
      end
      else if (op[5:3] == 3'b111)
      begin
        d.opa_select  = OPA_NPC;
        d.opb_select  = OPB_BR_DISP;
        d.cond_branch = 1'b1;
      end
      else
        d.illegal = 1'b1;
    end
    d.valid = f.valid && !d.illegal;
    return d;
  endfunction

  // kind 0..13 legal classes, 14 illegal encodings
  function automatic inst_t make_inst(input int kind);
    inst_t       w;
    logic [31:0] r;
    w = $urandom;                             // random fields everywhere
    r = $urandom;
    case (kind)
      0:  begin w[31:26] = 6'h10; w[11:5] = ARITH_FUNCS[(r % 7) * 7 +: 7]; end
      1:  begin w[31:26] = 6'h11; w[11:5] = LOGIC_FUNCS[(r % 6) * 7 +: 7]; end
      2:  begin w[31:26] = 6'h12; w[11:5] = SHIFT_FUNCS[(r % 3) * 7 +: 7]; end
      3:  begin w[31:26] = 6'h13; w[11:5] = 7'h20; end
      4:  w[31:26] = 6'h08;                   // lda
      5:  w[31:26] = 6'h29;
      6:  w[31:26] = 6'h2b;                   // locked load
      7:  w[31:26] = 6'h2d;
      8:  w[31:26] = 6'h2f;                   // conditional store
      9:  w[31:26] = 6'h1a;                   // jump group
      10: w[31:26] = 6'h30;
      11: w[31:26] = 6'h34;
      12: w[31:29] = 3'b111;                  // 0x38..0x3f cond branches
      13: w = 32'h0000_0000;                  // halt
      default:
        case (r % 3)
          0: w[31:26] = BAD_OPCODES[(r[31:8] % 13) * 6 +: 6];   // upper bits, any entry
          1:
          begin
            w[31:28] = 4'b0100;               // operate, any group
            w[27:26] = r[3:2];
            w[11:5]  = 7'h7f;                 // no group knows it
          end
          default:
          begin
            w[31:26] = 6'h00;
            w[0]     = 1'b1;                  // nonzero pal function
          end
        endcase
    endcase
    return w;
  endfunction

  function automatic fetch_t idle_fetch();
    fetch_t f;
    f.inst  = $urandom;                       // junk under a clear valid
    f.npc   = {$urandom, $urandom};
    f.valid = 1'b0;
    return f;
  endfunction

  task automatic report_failure();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_decoded(input decoded_t got, input decoded_t exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
      report_failure();
    end
  endtask

  task automatic check_count(input count_t got, input count_t exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s, got %0d expected %0d", $time, what, got, exp);
      report_failure();
    end
  endtask

  // caps and fetch offer for one cycle, stalls every 40 cycles
  task automatic drive_cycle(input int cycle);
    int          phase;
    int          offer;
    int unsigned r;
    phase   = cycle % 40;
    r       = $urandom_range(0, 9);
    rob_cap = count_t'($urandom_range(0, 2));
    rs_cap  = count_t'($urandom_range(0, 2));
    if (phase >= 20 && phase < 26)
      rob_cap = 2'd0;                         // rob full
    else if (phase >= 30 && phase < 35)
      rs_cap = 2'd0;                          // stations full
    offer = (r == 0) ? 0 : ((r < 3) ? 1 : 2);
    if (offer > STREAM_LEN - pos)
      offer = STREAM_LEN - pos;
    fetch0 = (offer >= 1) ? stream[pos] : idle_fetch();
    fetch1 = (offer == 2) ? stream[pos + 1] : idle_fetch();
  endtask

  initial
  begin : stimulus
    int cycle;
    int kind;
    fetch0  = '0;
    fetch1  = '0;
    rob_cap = 2'd0;
    rs_cap  = 2'd0;
    void'($urandom(SEED));
    for (int i = 0; i < STREAM_LEN; i++)
    begin
      kind            = (i < 15) ? i : int'($urandom_range(0, 14));   // every class up front
      stream[i].inst  = make_inst(kind);
      stream[i].npc   = {$urandom, $urandom};
      stream[i].valid = 1'b1;
    end
    @(negedge clock);
    while (reset)
      @(negedge clock);
    cycle = 0;
    while (dispatched_total < STREAM_LEN)
    begin
      pos = pos + accepted_cnt;               // fetch re-presents the rest
      drive_cycle(cycle);
      cycle++;
      @(negedge clock);
    end
    #2;
    check_count(dispatch_num, 2'd0, "dispatch count with an empty window");
    check_count(fetch_need, 2'd2, "fetch need with an empty window");
    $display("*** PASSED ***");
    $finish;
  end

  // mid-cycle check, then the model takes this cycle's edge
  initial
  begin : compare
    int       held;
    int       disp;
    int       need;
    int       offered;
    int       accept;
    int       idx;
    logic     first;
    decoded_t exp_slot;
    first = 1'b1;
    @(negedge clock);
    while (reset)
      @(negedge clock);
    forever
    begin
      #2;
      held = model_q.size();
      disp = min_of(held, min_of(int'(rob_cap), int'(rs_cap)));
      need = 2 - (held - disp);
      if (first)
      begin
        check_count(dispatch_num, 2'd0, "dispatch count after reset");
        check_count(fetch_need, 2'd2, "fetch need after reset");
        first = 1'b0;
      end
      check_count(dispatch_num, count_t'(disp), "dispatch count");
      check_count(fetch_need, count_t'(need), "fetch need");
      if (disp >= 1)
      begin
        exp_slot = model_q.pop_front();
        idx      = idx_q.pop_front();
        check_decoded(slot0, exp_slot, $sformatf("slot0, instruction %0d", idx));
      end
      if (disp == 2)
      begin
        exp_slot = model_q.pop_front();
        idx      = idx_q.pop_front();
        check_decoded(slot1, exp_slot, $sformatf("slot1, instruction %0d", idx));
      end
      dispatched_total += disp;
      offered = 0;
      if (fetch0.valid)
        offered = fetch1.valid ? 2 : 1;
      accept = min_of(offered, need);         // oldest offers first
      if (accept >= 1)
      begin
        model_q.push_back(ref_decode(fetch0));
        idx_q.push_back(pos);
      end
      if (accept == 2)
      begin
        model_q.push_back(ref_decode(fetch1));
        idx_q.push_back(pos + 1);
      end
      accepted_cnt = accept;
      @(negedge clock);
    end
  end

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    report_failure();
  end

endmodule
